/* arch_pkg.sv */
// architectural register definitions
`default_nettype none

package arch_pkg;

	// ==========================================================
	// register file shape
	// ==========================================================

	// the core names eight architectural registers
	localparam int AREGS_DEF = 8;

	// dispatch and commit both run three slots wide
	localparam int QSLOTS_DEF = 3;

	// index of one architectural register
	// register 0 reads as constant and is never marked invalid
	typedef logic [2:0] areg_t;

	// the hardwired register
	localparam areg_t AREG_ZERO = 3'd0;

endpackage

`default_nettype wire

/* rob_pkg.sv */
// reorder buffer definitions
`default_nettype none

package rob_pkg;

	// ==========================================================
	// buffer shape
	// ==========================================================

	// eight entries, so a tag is a plain 3 bit index that wraps
	localparam int RENTRIES_DEF = 8;

	// position of one instruction in the circular buffer
	typedef logic [2:0] rob_tag_t;

	// ==========================================================
	// entry layout
	// ==========================================================

	// one queued instruction as the buffer keeps it
	// tgt only means something when rfw is set
	typedef struct packed {
		arch_pkg::areg_t tgt;
		logic rfw;
		logic done;
	} rob_entry_t;

	// a freshly queued entry is never done yet
	localparam logic ENTRY_NOT_DONE = 1'b0;

endpackage

`default_nettype wire

/* dispatch_if.sv */
// dispatch slot bundle
`timescale 1ns/10ps
`default_nettype none

interface dispatch_if #(
	parameter int QSLOTS = arch_pkg::QSLOTS_DEF
);
	import arch_pkg::*;
	import rob_pkg::*;

	// one strobe per slot that was accepted this cycle
	logic [QSLOTS-1:0] queued;
	// slot writes a register
	logic [QSLOTS-1:0] rfw;
	// destination register of each slot
	areg_t rd [QSLOTS];
	// buffer tag handed to each accepted slot
	rob_tag_t tag [QSLOTS];

	// the dispatch stage drives every field
	modport producer (output queued, rfw, rd, tag);
	// the buffer needs the tag to place the entry
	modport rob_side (input queued, rfw, rd, tag);
	// the valid tracker only clears bits, so no tag
	modport tracker_side (input queued, rfw, rd);

endinterface

`default_nettype wire

/* commit_if.sv */
// commit bus bundle
`timescale 1ns/10ps
`default_nettype none

interface commit_if #(
	parameter int AREGS = arch_pkg::AREGS_DEF,
	parameter int QSLOTS = arch_pkg::QSLOTS_DEF,
	parameter int RENTRIES = rob_pkg::RENTRIES_DEF
);
	import arch_pkg::*;
	import rob_pkg::*;

	// per commit port, oldest entry on port 0
	logic [QSLOTS-1:0] v;
	logic [QSLOTS-1:0] rfw;
	rob_tag_t tag [QSLOTS];
	areg_t tgt [QSLOTS];
	// entries that are occupied and survive a miss in this cycle
	logic [RENTRIES-1:0] live;
	// registers still targeted by some surviving entry
	logic [AREGS-1:0] live_tgt;

	modport rob_side (output v, rfw, tag, tgt, live, live_tgt);
	modport tracker_side (input v, rfw, tag, tgt, live, live_tgt);

endinterface

`default_nettype wire

/* rename_dispatch.sv */
// rename and dispatch stage
`timescale 1ns/10ps
`default_nettype none

module rename_dispatch #(
	parameter int AREGS = arch_pkg::AREGS_DEF,
	parameter int QSLOTS = arch_pkg::QSLOTS_DEF,
	parameter int RENTRIES = rob_pkg::RENTRIES_DEF
) (
	input  logic clk,
	input  logic rst,
	input  logic [QSLOTS-1:0] slot_v,
	input  logic [QSLOTS-1:0] slot_rfw,
	input  arch_pkg::areg_t slot_rd [QSLOTS],
	input  logic [$clog2(RENTRIES+1)-1:0] free_cnt,
	input  logic miss_v,
	input  rob_pkg::rob_tag_t miss_tag,
	dispatch_if.producer disp,
	output rob_pkg::rob_tag_t rf_source [AREGS]
);
	import rob_pkg::*;

	localparam int CW = $clog2(RENTRIES + 1);

	// next tag to hand out, kept in step with the buffer tail
	rob_tag_t tail;
	// number of slots accepted so far in this cycle
	logic [CW-1:0] nq;
	// set once a valid slot has been refused
	logic blocked;
	// helper terms for the ordering check
	logic refused_seen;
	logic gap;

	// ==========================================================
	// in-order acceptance
	// ==========================================================

	// walk the slots from 0 upward, an empty slot is simply skipped
	// but the first refused valid slot blocks everything above it
	always_comb begin
		nq = '0;
		blocked = miss_v;
		for (int s = 0; s < QSLOTS; s++) begin
			disp.queued[s] = 1'b0;
			disp.rfw[s] = slot_rfw[s];
			disp.rd[s] = slot_rd[s];
			// consecutive tags counted from the tail
			disp.tag[s] = tail + rob_tag_t'(nq);
			if (slot_v[s]) begin
				if (!blocked && nq < free_cnt) begin
					disp.queued[s] = 1'b1;
					nq = nq + 1'b1;
				end else begin
					blocked = 1'b1;
				end
			end
		end
	end

	// ==========================================================
	// tail pointer and source table
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			tail <= '0;
			for (int a = 0; a < AREGS; a++)
				rf_source[a] <= '0;
		end else begin
			// a miss throws away everything younger than the branch
			if (miss_v)
				tail <= miss_tag + 1'b1;
			else
				tail <= tail + rob_tag_t'(nq);
			// ascending order lets the youngest writer of a register win
			for (int s = 0; s < QSLOTS; s++)
				if (disp.queued[s] && slot_rfw[s])
					rf_source[slot_rd[s]] <= disp.tag[s];
		end
	end

	// a queued slot above a refused valid slot breaks program order
	always_comb begin
		refused_seen = 1'b0;
		gap = 1'b0;
		for (int s = 0; s < QSLOTS; s++) begin
			if (disp.queued[s] && refused_seen)
				gap = 1'b1;
			if (slot_v[s] && !disp.queued[s])
				refused_seen = 1'b1;
		end
	end

	a_in_order: assert property (@(posedge clk) disable iff (rst) !gap);

endmodule

`default_nettype wire

/* reorder_buffer.sv */
// reorder buffer
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer #(
	parameter int AREGS = arch_pkg::AREGS_DEF,
	parameter int QSLOTS = arch_pkg::QSLOTS_DEF,
	parameter int RENTRIES = rob_pkg::RENTRIES_DEF
) (
	input  logic clk,
	input  logic rst,
	dispatch_if.rob_side disp,
	input  logic done_v,
	input  rob_pkg::rob_tag_t done_tag,
	input  logic miss_v,
	input  rob_pkg::rob_tag_t miss_tag,
	output logic [$clog2(RENTRIES+1)-1:0] free_cnt,
	commit_if.rob_side cmt
);
	import rob_pkg::*;

	localparam int CW = $clog2(RENTRIES + 1);

	// occupancy of the entry store follows from head and count alone
	rob_entry_t ent [RENTRIES];
	rob_tag_t head;
	logic [CW-1:0] count;

	// age of the missed branch relative to the head
	rob_tag_t miss_off;
	// entries left after a miss, before this cycle's commits
	logic [CW-1:0] keep_cnt;
	logic [CW-1:0] nq;
	logic [CW-1:0] ncmt;
	rob_tag_t cidx [QSLOTS];
	logic run;
	logic [RENTRIES-1:0] occ;
	logic [AREGS-1:0] ltgt;

	assign free_cnt = CW'(RENTRIES) - count;
	assign miss_off = miss_tag - head;
	assign keep_cnt = (CW'(miss_off) < count) ? CW'(miss_off) + 1'b1 : count;

	always_comb begin
		nq = '0;
		for (int s = 0; s < QSLOTS; s++)
			nq = nq + CW'(disp.queued[s]);
	end

	// ==========================================================
	// commit ports
	// ==========================================================

	// the oldest run of done entries, cut short at the first one
	// that is not done, not occupied or flushed by a miss
	always_comb begin
		run = 1'b1;
		ncmt = '0;
		for (int s = 0; s < QSLOTS; s++) begin
			cidx[s] = head + rob_tag_t'(s);
			run = run && (CW'(s) < count) && ent[cidx[s]].done
				&& (!miss_v || rob_tag_t'(s) <= miss_off);
			cmt.v[s] = run;
			cmt.tag[s] = cidx[s];
			cmt.tgt[s] = ent[cidx[s]].tgt;
			cmt.rfw[s] = ent[cidx[s]].rfw;
			ncmt = ncmt + CW'(run);
		end
	end

	// ==========================================================
	// live entries and live targets
	// ==========================================================

	always_comb begin
		ltgt = '0;
		for (int i = 0; i < RENTRIES; i++) begin
			// the offset from the head wraps at the tag width
			occ[i] = CW'(rob_tag_t'(rob_tag_t'(i) - head)) < count;
			// on a miss only the branch and the older entries remain
			cmt.live[i] = occ[i]
				&& (!miss_v || rob_tag_t'(rob_tag_t'(i) - head) <= miss_off);
			if (cmt.live[i] && ent[i].rfw)
				ltgt[ent[i].tgt] = 1'b1;
		end
	end

	assign cmt.live_tgt = ltgt;

	// ==========================================================
	// state update
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			count <= '0;
		end else begin
			head <= head + rob_tag_t'(ncmt);
			// no slot is queued in a miss cycle, so nq is zero then
			count <= (miss_v ? keep_cnt : count + nq) - ncmt;
		end
	end

	// the done flag lands at the edge and can commit a cycle later
	always_ff @(posedge clk) begin
		if (done_v)
			ent[done_tag].done <= 1'b1;
		for (int s = 0; s < QSLOTS; s++)
			if (disp.queued[s])
				ent[disp.tag[s]] <= '{tgt: disp.rd[s], rfw: disp.rfw[s],
					done: ENTRY_NOT_DONE};
	end

	a_done_live: assert property (@(posedge clk) disable iff (rst)
		done_v |-> occ[done_tag]);
	a_no_overfill: assert property (@(posedge clk) disable iff (rst)
		nq <= free_cnt);

endmodule

`default_nettype wire

/* regfile_valid.sv */
// register valid tracker
`timescale 1ns/10ps
`default_nettype none

module regfile_valid #(
	parameter int AREGS = arch_pkg::AREGS_DEF,
	parameter int QSLOTS = arch_pkg::QSLOTS_DEF
) (
	input  logic clk,
	input  logic rst,
	dispatch_if.tracker_side disp,
	commit_if.tracker_side cmt,
	input  logic miss_v,
	input  rob_pkg::rob_tag_t rf_source [AREGS],
	output logic [AREGS-1:0] rf_v,
	output logic [AREGS-1:0] reg_is_valid
);
	import arch_pkg::*;
	import rob_pkg::*;

	// target and recorded source of the commit port being looked at
	areg_t tgt;
	rob_tag_t src;

	// ==========================================================
	// early view
	// ==========================================================

	// the value rf_v takes at the next edge before any queued clear,
	// so a read-through register file can pick the result up a cycle early
	always_comb begin
		reg_is_valid = rf_v;
		tgt = '0;
		src = '0;
		// a miss frees every register no survivor is going to write
		if (miss_v)
			for (int n = 0; n < AREGS; n++)
				if (!cmt.live_tgt[n])
					reg_is_valid[n] = 1'b1;
		// a commit only validates if it is still the newest writer
		// or the recorded writer has been flushed from the buffer
		for (int s = 0; s < QSLOTS; s++) begin
			tgt = cmt.tgt[s];
			src = rf_source[tgt];
			if (cmt.v[s] && cmt.rfw[s] && (src == cmt.tag[s] || !cmt.live[src]))
				reg_is_valid[tgt] = 1'b1;
		end
		reg_is_valid[AREG_ZERO] = 1'b1;
	end

	// ==========================================================
	// registered bits
	// ==========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			rf_v <= '1;
		end else begin
			rf_v <= reg_is_valid;
			// queued writes come last so the clear beats a same-cycle commit
			for (int s = 0; s < QSLOTS; s++)
				if (disp.queued[s] && disp.rfw[s] && disp.rd[s] != AREG_ZERO)
					rf_v[disp.rd[s]] <= 1'b0;
		end
	end

	a_reg0_valid: assert property (@(posedge clk) disable iff (rst)
		rf_v[AREG_ZERO]);

endmodule

`default_nettype wire

/* rename_core_top.sv */
// rename core top level
`timescale 1ns/10ps
`default_nettype none

module rename_core_top #(
	parameter int AREGS = arch_pkg::AREGS_DEF,
	parameter int QSLOTS = arch_pkg::QSLOTS_DEF,
	parameter int RENTRIES = rob_pkg::RENTRIES_DEF
) (
	input  logic clk,
	input  logic rst,
	input  logic [QSLOTS-1:0] slot_v,
	input  logic [QSLOTS-1:0] slot_rfw,
	input  arch_pkg::areg_t slot_rd [QSLOTS],
	input  logic done_v,
	input  rob_pkg::rob_tag_t done_tag,
	input  logic miss_v,
	input  rob_pkg::rob_tag_t miss_tag,
	output logic [QSLOTS-1:0] queued_on,
	output logic [QSLOTS-1:0] commit_v,
	output rob_pkg::rob_tag_t commit_tag [QSLOTS],
	output arch_pkg::areg_t commit_tgt [QSLOTS],
	output logic [AREGS-1:0] rf_v,
	output logic [AREGS-1:0] reg_is_valid
);
	import rob_pkg::*;

	localparam int CW = $clog2(RENTRIES + 1);

	logic [CW-1:0] free_cnt;
	rob_tag_t rf_source [AREGS];

	dispatch_if #(.QSLOTS(QSLOTS)) disp ();
	commit_if #(.AREGS(AREGS), .QSLOTS(QSLOTS), .RENTRIES(RENTRIES)) cmt ();

	// dispatch allocates tags and owns the register source table
	rename_dispatch #(.AREGS(AREGS), .QSLOTS(QSLOTS), .RENTRIES(RENTRIES))
	i_rename_dispatch (
		.clk(clk), .rst(rst), .slot_v(slot_v), .slot_rfw(slot_rfw),
		.slot_rd(slot_rd), .free_cnt(free_cnt), .miss_v(miss_v),
		.miss_tag(miss_tag), .disp(disp), .rf_source(rf_source)
	);

	reorder_buffer #(.AREGS(AREGS), .QSLOTS(QSLOTS), .RENTRIES(RENTRIES))
	i_reorder_buffer (
		.clk(clk), .rst(rst), .disp(disp), .done_v(done_v),
		.done_tag(done_tag), .miss_v(miss_v), .miss_tag(miss_tag),
		.free_cnt(free_cnt), .cmt(cmt)
	);

	regfile_valid #(.AREGS(AREGS), .QSLOTS(QSLOTS)) i_regfile_valid (
		.clk(clk), .rst(rst), .disp(disp), .cmt(cmt), .miss_v(miss_v),
		.rf_source(rf_source), .rf_v(rf_v), .reg_is_valid(reg_is_valid)
	);

	assign queued_on = disp.queued;
	assign commit_v = cmt.v;
	assign commit_tag = cmt.tag;
	assign commit_tgt = cmt.tgt;

endmodule

`default_nettype wire

/* tb_rename_core.sv */
// rename core testbench
`timescale 1ns/10ps
`default_nettype none

module tb_rename_core;
	import arch_pkg::*;
	import rob_pkg::*;

	localparam int AREGS = 8;
	localparam int QSLOTS = 3;
	localparam int RENTRIES = 8;
	// random cycles after reset, and the watchdog limit with some slack
	localparam int NCYC = 3000;
	localparam int LIMIT = NCYC + 4 + 50;

	logic clk;
	logic rst;
	logic [QSLOTS-1:0] slot_v;
	logic [QSLOTS-1:0] slot_rfw;
	areg_t slot_rd [QSLOTS];
	logic done_v;
	rob_tag_t done_tag;
	logic miss_v;
	rob_tag_t miss_tag;
	logic [QSLOTS-1:0] queued_on;
	logic [QSLOTS-1:0] commit_v;
	rob_tag_t commit_tag [QSLOTS];
	areg_t commit_tgt [QSLOTS];
	logic [AREGS-1:0] rf_v;
	logic [AREGS-1:0] reg_is_valid;

	// reference state of the buffer, the source table and the valid bits
	rob_tag_t m_head;
	int m_count;
	areg_t m_tgt [RENTRIES];
	logic m_rfw [RENTRIES];
	logic m_done [RENTRIES];
	rob_tag_t m_src [AREGS];
	logic [AREGS-1:0] m_rfv;

	// expected outputs of the current cycle
	logic [QSLOTS-1:0] exp_queued;
	logic [QSLOTS-1:0] exp_cv;
	rob_tag_t exp_ctag [QSLOTS];
	areg_t exp_ctgt [QSLOTS];
	logic [AREGS-1:0] exp_riv;

	logic [31:0] lfsr;
	int cyc_cnt;
	int n_checks;
	int n_errors;

	rename_core_top #(.AREGS(AREGS), .QSLOTS(QSLOTS), .RENTRIES(RENTRIES)) i_rename_core_top (
		.clk(clk), .rst(rst), .slot_v(slot_v), .slot_rfw(slot_rfw), .slot_rd(slot_rd),
		.done_v(done_v), .done_tag(done_tag), .miss_v(miss_v), .miss_tag(miss_tag),
		.queued_on(queued_on), .commit_v(commit_v), .commit_tag(commit_tag),
		.commit_tgt(commit_tgt), .rf_v(rf_v), .reg_is_valid(reg_is_valid)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ==========================================================
	// random source
	// ==========================================================

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step for every bit handed out
	function automatic int unsigned take_bits(input int n);
		int unsigned r;
		r = 0;
		for (int i = 0; i < n; i++) begin
			r = (r << 1) | lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	// ==========================================================
	// reference model
	// ==========================================================

	// computes this cycle's outputs from the inputs and moves the
	// reference state on by one rising edge
	function automatic void model_cycle();
		rob_tag_t moff;
		rob_tag_t idx;
		rob_tag_t off;
		rob_tag_t src;
		rob_tag_t q_tag [QSLOTS];
		areg_t tg;
		int nq;
		int ncmt;
		int keep;
		logic blocked;
		logic run;
		logic [RENTRIES-1:0] live;
		logic [AREGS-1:0] ltgt;
		nq = 0;
		blocked = miss_v;
		moff = miss_tag - m_head;
		// slots from 0 upward, the first refused valid slot stops the rest
		for (int s = 0; s < QSLOTS; s++) begin
			exp_queued[s] = 1'b0;
			q_tag[s] = rob_tag_t'(m_head + m_count + nq);
			if (slot_v[s]) begin
				if (!blocked && nq < RENTRIES - m_count) begin
					exp_queued[s] = 1'b1;
					nq++;
				end else begin
					blocked = 1'b1;
				end
			end
		end
		// commits retire the oldest done run, never past a missed branch
		run = 1'b1;
		ncmt = 0;
		for (int s = 0; s < QSLOTS; s++) begin
			idx = m_head + rob_tag_t'(s);
			run = run && s < m_count && m_done[idx] && (!miss_v || s <= moff);
			exp_cv[s] = run;
			exp_ctag[s] = idx;
			exp_ctgt[s] = m_tgt[idx];
			ncmt += int'(run);
		end
		// entries surviving this cycle and the registers they still write
		ltgt = '0;
		for (int i = 0; i < RENTRIES; i++) begin
			off = rob_tag_t'(i) - m_head;
			live[i] = off < m_count && (!miss_v || off <= moff);
			if (live[i] && m_rfw[i])
				ltgt[m_tgt[i]] = 1'b1;
		end
		exp_riv = m_rfv;
		if (miss_v)
			exp_riv = exp_riv | ~ltgt;
		for (int s = 0; s < QSLOTS; s++) begin
			tg = exp_ctgt[s];
			src = m_src[tg];
			if (exp_cv[s] && m_rfw[exp_ctag[s]] && (src == exp_ctag[s] || !live[src]))
				exp_riv[tg] = 1'b1;
		end
		exp_riv[0] = 1'b1;
		// the edge: queued writes clear after the commit and miss terms
		m_rfv = exp_riv;
		if (done_v)
			m_done[done_tag] = 1'b1;
		for (int s = 0; s < QSLOTS; s++) begin
			if (exp_queued[s]) begin
				m_tgt[q_tag[s]] = slot_rd[s];
				m_rfw[q_tag[s]] = slot_rfw[s];
				m_done[q_tag[s]] = 1'b0;
				if (slot_rfw[s])
					m_src[slot_rd[s]] = q_tag[s];
				if (slot_rfw[s] && slot_rd[s] != 0)
					m_rfv[slot_rd[s]] = 1'b0;
			end
		end
		keep = (moff < m_count) ? moff + 1 : m_count;
		m_count = (miss_v ? keep : m_count + nq) - ncmt;
		m_head = m_head + rob_tag_t'(ncmt);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("[FAIL] cycle %0d %s: got %0h, expected %0h", cyc_cnt, name, got, exp);
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			check("rf_v", rf_v, m_rfv);
			model_cycle();
			check("queued_on", queued_on, exp_queued);
			check("commit_v", commit_v, exp_cv);
			for (int s = 0; s < QSLOTS; s++) begin
				if (exp_cv[s]) begin
					check($sformatf("commit_tag[%0d]", s), commit_tag[s], exp_ctag[s]);
					check($sformatf("commit_tgt[%0d]", s), commit_tgt[s], exp_ctgt[s]);
				end
			end
			check("reg_is_valid", reg_is_valid, exp_riv);
		end
	end

	// ==========================================================
	// stimulus
	// ==========================================================

	// done and miss only name live entries, and completion runs slow
	// in every other stretch of 128 cycles so the buffer fills up
	task automatic drive_inputs();
		logic slow;
		slow = ((cyc_cnt / 128) % 2) == 1;
		slot_v = QSLOTS'(take_bits(QSLOTS));
		slot_rfw = QSLOTS'(take_bits(QSLOTS));
		for (int s = 0; s < QSLOTS; s++)
			slot_rd[s] = areg_t'(take_bits(3));
		done_v = 1'b0;
		done_tag = '0;
		miss_v = 1'b0;
		miss_tag = '0;
		if (m_count > 0) begin
			done_v = take_bits(2) < (slow ? 1 : 3);
			done_tag = m_head + rob_tag_t'(take_bits(3) % m_count);
			miss_v = take_bits(4) == 0;
			miss_tag = m_head + rob_tag_t'(take_bits(3) % m_count);
		end
	endtask

	always @(posedge clk) begin
		cyc_cnt++;
		if (cyc_cnt > LIMIT) begin
			$display("timeout: the run did not end within %0d cycles", LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	initial begin
		lfsr = 32'hd46d_c7b2;
		cyc_cnt = 0;
		n_checks = 0;
		n_errors = 0;
		rst = 1'b1;
		slot_v = '0;
		slot_rfw = '0;
		for (int s = 0; s < QSLOTS; s++)
			slot_rd[s] = '0;
		done_v = 1'b0;
		done_tag = '0;
		miss_v = 1'b0;
		miss_tag = '0;
		m_head = '0;
		m_count = 0;
		m_rfv = '1;
		for (int i = 0; i < RENTRIES; i++) begin
			m_tgt[i] = '0;
			m_rfw[i] = 1'b0;
			m_done[i] = 1'b0;
		end
		for (int a = 0; a < AREGS; a++)
			m_src[a] = '0;
		repeat (4) @(posedge clk);
		for (int k = 0; k < NCYC; k++) begin
			#2;
			rst = 1'b0;
			drive_inputs();
			@(posedge clk);
		end
		#2;
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
arch_pkg.sv
rob_pkg.sv
dispatch_if.sv
commit_if.sv
rename_dispatch.sv
reorder_buffer.sv
regfile_valid.sv
rename_core_top.sv
tb_rename_core.sv

/* Makefile */
SRCS := $(wildcard *.sv) all.f

all: run

obj_dir/Vtb_rename_core: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rename_core

run: obj_dir/Vtb_rename_core
	./obj_dir/Vtb_rename_core | tee sim.log
	@grep -qx "Finished with no errors" sim.log
	@! grep -qx "Finished with errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
